//--- hw/ngp_video_defs.svh
// scroll-plane sizing and raster limits, included by every video RTL file
`ifndef NGP_VIDEO_DEFS_SVH
`define NGP_VIDEO_DEFS_SVH

// two identical tile planes
`define NGP_SCR_N 2

// map word address, 32x32 entries
`define NGP_MAP_AW 10

// character ram word address, 512 characters x 8 rows
`define NGP_CHR_AW 12

// dots per line and lines per frame
// active pixels are hdump below 160
`define NGP_H_TOTAL 256
`define NGP_V_TOTAL 160

`endif

//--- hw/ngp_bus_pkg.sv
// cpu bus types for the scroll subsystem, used by the control block and the testbench
package ngp_bus_pkg;

    // region select, taken from cpu address bits 13:12
    // map regions carry the plane number in bit 0
    typedef enum logic [1:0] {
        REG_CHR  = 2'd0,
        REG_CTL  = 2'd1,
        REG_MAP0 = 2'd2,
        REG_MAP1 = 2'd3
    } cpu_region_t;

    // one scroll word per plane
    typedef struct packed {
        logic [7:0] vpos;
        logic [7:0] hpos;
    } scroll_reg_t;

endpackage

//--- hw/ngp_video_pkg.sv
// video data types for the scroll planes and the mixer
package ngp_video_pkg;

    // decoded view of a tile map word
    typedef struct packed {
        // mirror the tile left to right
        logic       hflip;
        // mirror the tile top to bottom
        logic       vflip;
        // palette select bit
        logic       pal;
        logic [3:0] unused;
        // character number
        logic [8:0] code;
    } map_fields_t;

    // map word as the cpu writes it and as the scanner reads it
    typedef union packed {
        logic [15:0] raw;
        map_fields_t f;
    } map_entry_t;

    // mixed output pixel
    typedef struct packed {
        // winning plane, 0 covers 1
        logic       layer;
        logic       pal;
        // 2bpp colour, 0 is transparent
        logic [1:0] colour;
    } mix_pxl_t;

endpackage

//--- hw/scr_bus_if.sv
// cpu map access from the control block to one scroll plane
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

interface scr_bus_if;

    // map word address
    logic [`NGP_MAP_AW-1:0] addr;
    // write data, merged by byte strobes
    logic [15:0] wdata;
    // one write enable per byte, high byte in bit 1
    logic [1:0] we;
    // synchronous read of addr, one clock later
    logic [15:0] rdata;

    modport ctrl (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport plane (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

//--- hw/ngp_scr_ctrl.sv
// raster timing, cpu decode, scroll and enable registers and readback for the scroll planes
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module ngp_scr_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [13:1]            cpu_addr,
    input  logic [15:0]            cpu_dout,
    input  logic [1:0]             dsn,
    input  logic                   scr_cs,
    output logic [15:0]            cpu_din,
    output logic [`NGP_CHR_AW-1:0] chram_cpu_addr,
    output logic [1:0]             chram_cpu_we,
    input  logic [15:0]            chram_cpu_q,
    scr_bus_if.ctrl                bus [`NGP_SCR_N],
    output logic                   pxl_cen,
    output logic [7:0]             hdump,
    output logic [7:0]             vdump,
    output logic [7:0]             hpos [`NGP_SCR_N],
    output logic [7:0]             vpos [`NGP_SCR_N],
    output logic                   en [`NGP_SCR_N]
);

localparam int N = `NGP_SCR_N;
localparam int CHR_AW = `NGP_CHR_AW;
localparam int SW = $clog2(N);
// enable bits live in control word 2
localparam logic [1:0] CTL_EN_WORD = 2'd2;

ngp_bus_pkg::cpu_region_t region;
ngp_bus_pkg::cpu_region_t rd_region;
ngp_bus_pkg::scroll_reg_t scroll [N];
logic [1:0]   we;
logic [1:0]   ctl_word;
logic [N-1:0] en_r;
logic [N-1:0] map_we;
logic [15:0]  map_q [N];
logic [15:0]  ctl_rd;
logic [15:0]  ctl_q;
logic         rd_cs;

// raster, one dot every second clock
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pxl_cen <= 1'b0;
        hdump   <= '0;
        vdump   <= '0;
    end else begin
        pxl_cen <= ~pxl_cen;
        if (pxl_cen) begin
            if (hdump == 8'(`NGP_H_TOTAL - 1)) begin
                hdump <= '0;
                vdump <= (vdump == 8'(`NGP_V_TOTAL - 1)) ? '0 : vdump + 8'd1;
            end else begin
                hdump <= hdump + 8'd1;
            end
        end
    end
end

assign region   = ngp_bus_pkg::cpu_region_t'(cpu_addr[13:12]);
assign we       = ~dsn & {2{scr_cs}};
assign ctl_word = cpu_addr[2:1];

// cpu window covers the lower 2048 character words
assign chram_cpu_addr = CHR_AW'(cpu_addr[11:1]);
assign chram_cpu_we   = (region == ngp_bus_pkg::REG_CHR) ? we : 2'b00;

// per plane map steering and register fan-out
for (genvar i = 0; i < N; i++) begin : g_plane
    localparam ngp_bus_pkg::cpu_region_t MAP_REG =
        ngp_bus_pkg::cpu_region_t'(ngp_bus_pkg::REG_MAP0 + i);
    assign bus[i].addr  = cpu_addr[`NGP_MAP_AW:1];
    assign bus[i].wdata = cpu_dout;
    assign bus[i].we    = (region == MAP_REG) ? we : 2'b00;
    assign map_we[i]    = |bus[i].we;
    assign map_q[i]     = bus[i].rdata;
    assign hpos[i]      = scroll[i].hpos;
    assign vpos[i]      = scroll[i].vpos;
    assign en[i]        = en_r[i];
end

// scroll words 0..N-1 then the enable word
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        for (int i = 0; i < N; i++) begin
            scroll[i] <= '0;
        end
        en_r <= '0;
    end else if (region == ngp_bus_pkg::REG_CTL) begin
        for (int i = 0; i < N; i++) begin
            if (ctl_word == 2'(i)) begin
                if (we[1]) scroll[i].vpos <= cpu_dout[15:8];
                if (we[0]) scroll[i].hpos <= cpu_dout[7:0];
            end
        end
        if (ctl_word == CTL_EN_WORD && we[0]) en_r <= cpu_dout[N-1:0];
    end
end

always_comb begin
    ctl_rd = '0;
    if (ctl_word == CTL_EN_WORD) begin
        ctl_rd[N-1:0] = en_r;
    end else if (int'(ctl_word) < N) begin
        ctl_rd = scroll[SW'(ctl_word)];
    end
end

// remember the access so data lines up with the ram outputs
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        rd_cs     <= 1'b0;
        rd_region <= ngp_bus_pkg::REG_CHR;
        ctl_q     <= '0;
    end else begin
        rd_cs     <= scr_cs;
        rd_region <= region;
        ctl_q     <= ctl_rd;
    end
end

always_comb begin
    cpu_din = '0;
    if (rd_cs) begin
        case (rd_region)
            ngp_bus_pkg::REG_CHR: cpu_din = chram_cpu_q;
            ngp_bus_pkg::REG_CTL: cpu_din = ctl_q;
            // map regions, plane number in the low bit
            default: cpu_din = map_q[rd_region[0]];
        endcase
    end
end

// no ram or plane sees a write while the chip select is idle
a_idle_no_we: assert property (@(posedge clk) disable iff (rst)
    !scr_cs |-> (chram_cpu_we == 2'b00 && map_we == '0));

endmodule

//--- hw/ngp_chram.sv
// shared character ram, one cpu port plus one read port per scroll plane
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module ngp_chram (
    input  logic                   clk,
    input  logic [`NGP_CHR_AW-1:0] cpu_addr,
    input  logic [15:0]            cpu_data,
    input  logic [1:0]             cpu_we,
    output logic [15:0]            cpu_q,
    input  logic [`NGP_CHR_AW-1:0] rd_addr [`NGP_SCR_N],
    output logic [15:0]            rd_data [`NGP_SCR_N]
);

localparam int N = `NGP_SCR_N;

// 512 characters x 8 rows, 8 pixels of 2 bits per word
logic [15:0] mem [2**`NGP_CHR_AW];

// cpu side, byte strobes merge into the stored word
always_ff @(posedge clk) begin
    if (cpu_we[0]) begin
        mem[cpu_addr][7:0] <= cpu_data[7:0];
    end
    if (cpu_we[1]) begin
        mem[cpu_addr][15:8] <= cpu_data[15:8];
    end
    // read before write on the same address
    cpu_q <= mem[cpu_addr];
end

// plane side, data one clock after address
always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
        rd_data[i] <= mem[rd_addr[i]];
    end
end

endmodule

//--- hw/ngp_scr_plane.sv
// one scrolling tile plane with its own map ram, tile scanner and pixel shifter
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module ngp_scr_plane (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pxl_cen,
    input  logic [7:0]             hdump,
    input  logic [7:0]             vdump,
    input  logic [7:0]             hpos,
    input  logic [7:0]             vpos,
    input  logic                   en,
    scr_bus_if.plane               bus,
    output logic [`NGP_CHR_AW-1:0] chram_addr,
    input  logic [15:0]            chram_data,
    output logic [2:0]             pxl
);

// 32x32 map words
logic [15:0] map_mem [2**`NGP_MAP_AW];

ngp_video_pkg::map_entry_t scan_q;
logic [`NGP_MAP_AW-1:0] scan_addr;
logic [7:0]  heff;
logic [7:0]  veff;
// line that the tile fetched at this dot is shown on
logic [7:0]  vline;
logic [15:0] pxl_data;
// attributes of the tile being fetched
logic        hflip0;
logic        pal0;
// attributes of the tile being shifted out
logic        hflip;
logic        pal;

// a tile fetched in the last dots of a line only shows on the next line
assign vline = (hdump > 8'(`NGP_H_TOTAL - 8)) ?
               ((vdump == 8'(`NGP_V_TOTAL - 1)) ? 8'd0 : vdump + 8'd1) : vdump;

// effective position wraps at 256 in both directions
assign heff = hdump + hpos;
assign veff = vline + vpos;
// tile row then tile column
assign scan_addr = {veff[7:3], heff[7:3]};

// cpu port and scanner port of the map
always_ff @(posedge clk) begin
    if (bus.we[0]) begin
        map_mem[bus.addr][7:0] <= bus.wdata[7:0];
    end
    if (bus.we[1]) begin
        map_mem[bus.addr][15:8] <= bus.wdata[15:8];
    end
    bus.rdata  <= map_mem[bus.addr];
    // settles on the clock between dots
    scan_q.raw <= map_mem[scan_addr];
end

// tile boundary fetches the next row and loads the previous one
// so output runs 9 dots behind the effective column
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        chram_addr <= '0;
        hflip0     <= 1'b0;
        pal0       <= 1'b0;
        hflip      <= 1'b0;
        pal        <= 1'b0;
        pxl_data   <= '0;
    end else if (pxl_cen) begin
        if (heff[2:0] == 3'd0) begin
            chram_addr <= {scan_q.f.code, veff[2:0] ^ {3{scan_q.f.vflip}}};
            hflip0     <= scan_q.f.hflip;
            pal0       <= scan_q.f.pal;
            pxl_data   <= chram_data;
            hflip      <= hflip0;
            pal        <= pal0;
        end else begin
            // leftmost pixel sits in the top bits unless mirrored
            pxl_data <= hflip ? pxl_data >> 2 : pxl_data << 2;
        end
    end
end

assign pxl = en ? {pal, hflip ? pxl_data[1:0] : pxl_data[15:14]} : 3'd0;

// fetch address only moves at a tile edge dot
a_chram_tile_edge: assert property (@(posedge clk) disable iff (rst)
    $changed(chram_addr) |-> $past(pxl_cen && heff[2:0] == 3'd0));

endmodule

//--- hw/ngp_scr_mix.sv
// priority mixer of the scroll planes, registers each pixel with its raster position
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module ngp_scr_mix (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic [7:0]               hdump,
    input  logic [7:0]               vdump,
    input  logic [2:0]               pxl_in [`NGP_SCR_N],
    output ngp_video_pkg::mix_pxl_t  pxl,
    output logic [7:0]               pxl_h,
    output logic [7:0]               pxl_v
);

localparam int N = `NGP_SCR_N;
// 9 dots through the plane and one through this stage
localparam int DLY = 10;

ngp_video_pkg::mix_pxl_t mix;
logic [7:0] h_dly [DLY];
logic [7:0] v_dly [DLY];

// lowest plane with a nonzero colour wins
always_comb begin
    mix = '0;
    for (int i = N - 1; i >= 0; i--) begin
        if (pxl_in[i][1:0] != 2'd0) begin
            mix.layer  = 1'(i);
            mix.pal    = pxl_in[i][2];
            mix.colour = pxl_in[i][1:0];
        end
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pxl <= '0;
        for (int k = 0; k < DLY; k++) begin
            h_dly[k] <= '0;
            v_dly[k] <= '0;
        end
    end else if (pxl_cen) begin
        pxl      <= mix;
        h_dly[0] <= hdump;
        v_dly[0] <= vdump;
        for (int k = 1; k < DLY; k++) begin
            h_dly[k] <= h_dly[k-1];
            v_dly[k] <= v_dly[k-1];
        end
    end
end

// position of the dot now on pxl
assign pxl_h = h_dly[DLY-1];
assign pxl_v = v_dly[DLY-1];

// transparent output never names a layer or palette
a_clear_transparent: assert property (@(posedge clk) disable iff (rst)
    pxl.colour == 2'd0 |-> (pxl.layer == 1'b0 && pxl.pal == 1'b0));

endmodule

//--- hw/ngp_scr_top.sv
// scroll-plane subsystem top, cpu bus in and mixed pixels with their raster position out
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module ngp_scr_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [13:1]                                 cpu_addr,
    input  logic [15:0]                                 cpu_dout,
    input  logic [1:0]                                  dsn,
    input  logic                                        scr_cs,
    output logic [15:0]                                 cpu_din,
    output logic [$bits(ngp_video_pkg::mix_pxl_t)-1:0]  pxl,
    output logic [7:0]                                  pxl_h,
    output logic [7:0]                                  pxl_v
);

localparam int N = `NGP_SCR_N;

// raster shared by all planes
logic       pxl_cen;
logic [7:0] hdump;
logic [7:0] vdump;
// per plane controls
logic [7:0] hpos [N];
logic [7:0] vpos [N];
logic       en [N];
// character ram traffic
logic [`NGP_CHR_AW-1:0] chram_cpu_addr;
logic [1:0]             chram_cpu_we;
logic [15:0]            chram_cpu_q;
logic [`NGP_CHR_AW-1:0] chram_addr [N];
logic [15:0]            chram_data [N];
// plane pixels into the mixer
logic [2:0] plane_pxl [N];

scr_bus_if bus [N] ();

ngp_scr_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cpu_addr       (cpu_addr),
    .cpu_dout       (cpu_dout),
    .dsn            (dsn),
    .scr_cs         (scr_cs),
    .cpu_din        (cpu_din),
    .chram_cpu_addr (chram_cpu_addr),
    .chram_cpu_we   (chram_cpu_we),
    .chram_cpu_q    (chram_cpu_q),
    .bus            (bus),
    .pxl_cen        (pxl_cen),
    .hdump          (hdump),
    .vdump          (vdump),
    .hpos           (hpos),
    .vpos           (vpos),
    .en             (en)
);

ngp_chram u_chram (
    .clk      (clk),
    .cpu_addr (chram_cpu_addr),
    .cpu_data (cpu_dout),
    .cpu_we   (chram_cpu_we),
    .cpu_q    (chram_cpu_q),
    .rd_addr  (chram_addr),
    .rd_data  (chram_data)
);

for (genvar i = 0; i < N; i++) begin : g_plane
    ngp_scr_plane u_plane (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .hdump      (hdump),
        .vdump      (vdump),
        .hpos       (hpos[i]),
        .vpos       (vpos[i]),
        .en         (en[i]),
        .bus        (bus[i]),
        .chram_addr (chram_addr[i]),
        .chram_data (chram_data[i]),
        .pxl        (plane_pxl[i])
    );
end

// plane 0 lies over plane 1
ngp_scr_mix u_mix (
    .clk     (clk),
    .rst     (rst),
    .pxl_cen (pxl_cen),
    .hdump   (hdump),
    .vdump   (vdump),
    .pxl_in  (plane_pxl),
    .pxl     (pxl),
    .pxl_h   (pxl_h),
    .pxl_v   (pxl_v)
);

endmodule

//--- dv/tb_ngp_scr.sv
// directed testbench for the scroll-plane top, cpu bus access and pixel checks against a model
`timescale 1ns/10ps
`include "ngp_video_defs.svh"

module tb_ngp_scr;

// dots with a visible pixel on each line
localparam int ACTIVE_W = 160;
localparam int LINE_CLKS = `NGP_H_TOTAL * 2;
localparam int FRAME_CLKS = LINE_CLKS * `NGP_V_TOTAL;
// lines checked by all windows together
localparam int CHECK_LINES = 248;
// fills and line syncs fit easily in the spare frames
localparam int TIMEOUT_CLKS = CHECK_LINES * LINE_CLKS + 4 * FRAME_CLKS;

logic        clk;
logic        rst;
logic [13:1] cpu_addr;
logic [15:0] cpu_dout;
logic [1:0]  dsn;
logic        scr_cs;
logic [15:0] cpu_din;
logic [3:0]  pxl;
logic [7:0]  pxl_h;
logic [7:0]  pxl_v;

// model of everything the cpu can write
logic [15:0] chr_m [2048];
ngp_video_pkg::map_entry_t map_m [`NGP_SCR_N][2**`NGP_MAP_AW];
ngp_bus_pkg::scroll_reg_t scr_m [`NGP_SCR_N];
logic [1:0]  en_m;

logic [31:0] lcg_state;
int          checks;
int          errors;
int          test_errs;
int          cycles;

ngp_scr_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .cpu_addr (cpu_addr),
    .cpu_dout (cpu_dout),
    .dsn      (dsn),
    .scr_cs   (scr_cs),
    .cpu_din  (cpu_din),
    .pxl      (pxl),
    .pxl_h    (pxl_h),
    .pxl_v    (pxl_v)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// cycle budget for the whole run
initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CLKS) begin
        @(posedge clk);
        cycles++;
    end
    $display("timeout after %0d clocks, the tests did not finish", cycles);
    $display(">>> FAIL");
    $finish;
end

function automatic logic [15:0] rnd16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

// dsn is active low so a set bit keeps the old byte
function automatic logic [15:0] merge(logic [15:0] old, logic [15:0] din, logic [1:0] strb);
    return {strb[1] ? old[15:8] : din[15:8], strb[0] ? old[7:0] : din[7:0]};
endfunction

task automatic model_store(ngp_bus_pkg::cpu_region_t region, logic [10:0] word,
                           logic [15:0] data, logic [1:0] strb);
    case (region)
        ngp_bus_pkg::REG_CHR: chr_m[word] = merge(chr_m[word], data, strb);
        ngp_bus_pkg::REG_CTL: begin
            // words 0 and 1 hold the scroll and word 2 the enables in its low byte
            if (!word[1]) begin
                scr_m[word[0]] = merge(scr_m[word[0]], data, strb);
            end else if (!word[0] && !strb[0]) begin
                en_m = data[1:0];
            end
        end
        default: map_m[region[0]][word[9:0]].raw =
            merge(map_m[region[0]][word[9:0]].raw, data, strb);
    endcase
endtask

function automatic logic [15:0] expected_word(ngp_bus_pkg::cpu_region_t region,
                                              logic [10:0] word);
    case (region)
        ngp_bus_pkg::REG_CHR: return chr_m[word];
        ngp_bus_pkg::REG_CTL: begin
            if (!word[1]) return scr_m[word[0]];
            return word[0] ? 16'd0 : {14'd0, en_m};
        end
        default: return map_m[region[0]][word[9:0]].raw;
    endcase
endfunction

// {pal, colour} of one plane for the dot named h on line v
function automatic logic [2:0] expected_plane_pxl(logic p, logic [7:0] h, logic [7:0] v);
    logic [7:0]  x;
    logic [7:0]  y;
    logic [2:0]  row;
    logic [2:0]  idx;
    logic [15:0] w;
    ngp_video_pkg::map_entry_t e;
    x = h + scr_m[p].hpos;
    y = v + scr_m[p].vpos;
    e = map_m[p][{y[7:3], x[7:3]}];
    row = y[2:0] ^ {3{e.f.vflip}};
    idx = x[2:0] ^ {3{e.f.hflip}};
    w = chr_m[{e.f.code[7:0], row}];
    if (!en_m[p]) return 3'd0;
    // leftmost pixel in the top two bits
    return {e.f.pal, 2'(w >> {~idx, 1'b0})};
endfunction

function automatic ngp_video_pkg::mix_pxl_t expected_mix(logic [7:0] h, logic [7:0] v);
    logic [2:0] p0;
    logic [2:0] p1;
    ngp_video_pkg::mix_pxl_t m;
    p0 = expected_plane_pxl(1'b0, h, v);
    p1 = expected_plane_pxl(1'b1, h, v);
    m = '0;
    if (p0[1:0] != 2'd0) m = {1'b0, p0};
    else if (p1[1:0] != 2'd0) m = {1'b1, p1};
    return m;
endfunction

task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        test_errs++;
        $display("FAIL %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_pxl(string name, ngp_video_pkg::mix_pxl_t exp,
                         ngp_video_pkg::mix_pxl_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        test_errs++;
        $display("FAIL %s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_pos(string name, logic [7:0] eh, logic [7:0] ev,
                         logic [7:0] ah, logic [7:0] av);
    checks++;
    if (ah !== eh || av !== ev) begin
        errors++;
        test_errs++;
        $display("FAIL %s expected h %0d v %0d actual h %0d v %0d", name, eh, ev, ah, av);
    end
endtask

task automatic end_test(string name);
    if (test_errs == 0) $display("test %s: ok", name);
    else $display("test %s: %0d mismatches", name, test_errs);
    test_errs = 0;
endtask

task automatic bus_write(ngp_bus_pkg::cpu_region_t region, logic [10:0] word,
                         logic [15:0] data, logic [1:0] strb);
    @(negedge clk);
    cpu_addr = {region, word};
    cpu_dout = data;
    dsn      = strb;
    scr_cs   = 1'b1;
    @(negedge clk);
    scr_cs = 1'b0;
    dsn    = 2'b11;
    model_store(region, word, data, strb);
endtask

task automatic bus_read(ngp_bus_pkg::cpu_region_t region, logic [10:0] word,
                        output logic [15:0] data);
    @(negedge clk);
    cpu_addr = {region, word};
    dsn      = 2'b11;
    scr_cs   = 1'b1;
    // data arrives the clock after the access
    @(negedge clk);
    data   = cpu_din;
    scr_cs = 1'b0;
endtask

task automatic set_view(logic [7:0] h0, logic [7:0] v0, logic [7:0] h1, logic [7:0] v1,
                        logic [1:0] en);
    bus_write(ngp_bus_pkg::REG_CTL, 11'd0, {v0, h0}, 2'b00);
    bus_write(ngp_bus_pkg::REG_CTL, 11'd1, {v1, h1}, 2'b00);
    bus_write(ngp_bus_pkg::REG_CTL, 11'd2, {14'd0, en}, 2'b00);
endtask

// one dot is over when the named position moves
task automatic wait_dot();
    logic [7:0] last;
    last = pxl_h;
    do @(negedge clk); while (pxl_h == last);
endtask

task automatic check_window(string name, int lines);
    logic [7:0] eh;
    logic [7:0] ev;
    ngp_video_pkg::mix_pxl_t got;
    // let the fetch pipeline pick up the new view
    repeat (40) wait_dot();
    while (pxl_h != 8'd0) wait_dot();
    eh = 8'd0;
    ev = pxl_v;
    for (int d = 0; d < lines * `NGP_H_TOTAL; d++) begin
        got = pxl;
        check_pos(name, eh, ev, pxl_h, pxl_v);
        if (eh < 8'(ACTIVE_W)) check_pxl(name, expected_mix(eh, ev), got);
        wait_dot();
        eh = eh + 8'd1;
        if (eh == 8'd0) ev = (ev == 8'(`NGP_V_TOTAL - 1)) ? 8'd0 : ev + 8'd1;
    end
endtask

// plain tiles with codes inside the cpu window of the character ram
task automatic fill_memories();
    for (int i = 0; i < 2048; i++) begin
        bus_write(ngp_bus_pkg::REG_CHR, 11'(i), rnd16(), 2'b00);
    end
    for (int i = 0; i < 2**`NGP_MAP_AW; i++) begin
        bus_write(ngp_bus_pkg::REG_MAP0, 11'(i), rnd16() & 16'h1eff, 2'b00);
        bus_write(ngp_bus_pkg::REG_MAP1, 11'(i), rnd16() & 16'h1eff, 2'b00);
    end
endtask

task automatic merge_case(ngp_bus_pkg::cpu_region_t region, logic [10:0] word);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [15:0] got;
    a = rnd16() & 16'h1eff;
    b = rnd16() & 16'h1eff;
    r = rnd16();
    bus_write(region, word, a, 2'b00);
    // one byte lane only on the second write
    bus_write(region, word, b, r[0] ? 2'b01 : 2'b10);
    bus_read(region, word, got);
    check_word("bus_merge", expected_word(region, word), got);
endtask

task automatic test_bus_merge();
    logic [15:0] r;
    for (int i = 0; i < 4; i++) begin
        r = rnd16();
        merge_case(ngp_bus_pkg::REG_CHR, r[10:0]);
        merge_case(ngp_bus_pkg::REG_MAP0, r[10:0]);
        merge_case(ngp_bus_pkg::REG_MAP1, ~r[10:0]);
    end
    for (int w = 0; w < 3; w++) begin
        merge_case(ngp_bus_pkg::REG_CTL, 11'(w));
    end
    end_test("bus_merge");
endtask

task automatic test_plain_frame();
    set_view(8'h00, 8'h00, 8'h00, 8'h00, 2'b01);
    check_window("plain_frame", 160);
    end_test("plain_frame");
endtask

task automatic test_scroll();
    set_view(8'h2b, 8'h13, 8'h00, 8'h00, 2'b01);
    check_window("scroll", 20);
    // both offsets wrap past the 32 tile edge
    set_view(8'hf3, 8'hfd, 8'h00, 8'h00, 2'b01);
    check_window("scroll", 20);
    end_test("scroll");
endtask

task automatic test_flip();
    // rewrite plane 0 with random hflip, vflip and pal
    for (int i = 0; i < 2**`NGP_MAP_AW; i++) begin
        bus_write(ngp_bus_pkg::REG_MAP0, 11'(i), rnd16() & 16'hfeff, 2'b00);
    end
    set_view(8'h05, 8'h0e, 8'h00, 8'h00, 2'b01);
    check_window("flip", 20);
    end_test("flip");
endtask

task automatic test_priority();
    set_view(8'h31, 8'h07, 8'hc6, 8'h99, 2'b11);
    check_window("priority", 20);
    set_view(8'h31, 8'h07, 8'hc6, 8'h99, 2'b00);
    check_window("priority", 8);
    end_test("priority");
endtask

initial begin
    rst       = 1'b1;
    cpu_addr  = '0;
    cpu_dout  = '0;
    dsn       = 2'b11;
    scr_cs    = 1'b0;
    lcg_state = 32'h789a_7316;
    checks    = 0;
    errors    = 0;
    test_errs = 0;
    en_m      = 2'b00;
    for (int p = 0; p < `NGP_SCR_N; p++) begin
        scr_m[p] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fill_memories();
    test_bus_merge();
    test_plain_frame();
    test_scroll();
    test_flip();
    test_priority();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display(">>> PASS");
    end else begin
        $display(">>> FAIL");
    end
    $finish;
end

endmodule

//--- src.f
+incdir+hw
hw/ngp_bus_pkg.sv
hw/ngp_video_pkg.sv
hw/scr_bus_if.sv
hw/ngp_scr_ctrl.sv
hw/ngp_chram.sv
hw/ngp_scr_plane.sv
hw/ngp_scr_mix.sv
hw/ngp_scr_top.sv
dv/tb_ngp_scr.sv

//--- Makefile
TOP := tb_ngp_scr

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
